// ==== common/cache_pkg.sv ====
// shared cache widths and types; NUM_WAYS is fixed at 2 because the LRU state is one bit per set
`default_nettype none

package cache_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int WORD_W      = 32;  // processor data width
	localparam int WORD_ADDR_W = 30;  // processor word address
	localparam int LINE_WORDS  = 4;
	localparam int OFFS_W      = 2;   // word offset inside a line
	localparam int LINE_W      = WORD_W * LINE_WORDS;
	localparam int LINE_ADDR_W = WORD_ADDR_W - OFFS_W;

	localparam int DEF_SET_BITS = 2;  // four sets
	localparam int NUM_WAYS     = 2;

	// --------------------
	// line views
	// --------------------
	// flat for the memory side, word array for processor access
	typedef union packed {
		logic [LINE_W-1:0]                  flat;
		logic [LINE_WORDS-1:0][WORD_W-1:0] words;  // word 0 in the low bits
	} line_u;

	// controller states
	typedef enum logic [1:0] {
		READY     = 2'd0,
		WRITEBACK = 2'd1,
		REFILL    = 2'd2
	} cache_state_e;

	// memory request, held until the ready pulse
	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [LINE_ADDR_W-1:0] addr;   // line address
		line_u                  wdata;  // write-back line
	} mem_req_t;

endpackage

`default_nettype wire

// ==== cache/cache_tag_store.sv ====
// tags, valid and LRU bits of a 2-way cache; one LRU bit per set, so the way count cannot grow
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store #(
	parameter int SET_BITS = cache_pkg::DEF_SET_BITS
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [cache_pkg::WORD_ADDR_W-1:0]      i_addr,
	input  logic                                   i_touch,     // completing access
	input  logic                                   i_fill,      // refill done
	input  logic                                   i_fill_way,
	output logic                                   o_hit,
	output logic                                   o_hit_way,
	output logic                                   o_victim_way,
	output logic                                   o_victim_valid,
	output logic [cache_pkg::LINE_ADDR_W-SET_BITS-1:0] o_victim_tag
);
	import cache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_W    = LINE_ADDR_W - SET_BITS;

	logic [TAG_W-1:0]                   tag_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
	logic [NUM_SETS-1:0]                lru_q;    // names the least recently used way

	logic [SET_BITS-1:0] set_idx;
	logic [TAG_W-1:0]    addr_tag;
	logic [NUM_WAYS-1:0] way_hit;

	assign set_idx  = i_addr[OFFS_W +: SET_BITS];
	assign addr_tag = i_addr[WORD_ADDR_W-1 -: TAG_W];

	// --------------------
	// lookup
	// --------------------
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[set_idx][w] && (tag_mem[set_idx][w] == addr_tag);
		end
	end

	assign o_hit     = |way_hit;
	assign o_hit_way = ~way_hit[0];  // way 0 wins when both match

	// first empty way, else the LRU way
	always_comb begin
		if (!valid_q[set_idx][0]) begin
			o_victim_way = 1'b0;
		end else if (!valid_q[set_idx][1]) begin
			o_victim_way = 1'b1;
		end else begin
			o_victim_way = lru_q[set_idx];
		end
	end

	assign o_victim_valid = valid_q[set_idx][o_victim_way];
	assign o_victim_tag   = tag_mem[set_idx][o_victim_way];

	// --------------------
	// update
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			lru_q   <= '0;
		end else begin
			if (i_fill)
				valid_q[set_idx][i_fill_way] <= 1'b1;
			if (i_touch)
				lru_q[set_idx] <= ~o_hit_way;  // other way becomes LRU
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill)
			tag_mem[set_idx][i_fill_way] <= addr_tag;
	end

endmodule

`default_nettype wire

// ==== cache/cache_data_store.sv ====
// line storage of a 2-way cache; contents are undefined until a way is refilled
`timescale 1ns/1ps
`default_nettype none

module cache_data_store #(
	parameter int SET_BITS = cache_pkg::DEF_SET_BITS
) (
	input  logic                              clk,
	input  logic [cache_pkg::WORD_ADDR_W-1:0] i_addr,
	input  logic                              i_way,        // hit way or latched victim
	input  logic                              i_word_we,    // write hit
	input  logic [cache_pkg::WORD_W-1:0]      i_wdata,
	input  logic                              i_fill,
	input  cache_pkg::line_u                  i_fill_line,
	output logic [cache_pkg::WORD_W-1:0]      o_word,
	output cache_pkg::line_u                  o_victim_line
);
	import cache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;

	line_u data_mem [NUM_SETS][NUM_WAYS];

	logic [SET_BITS-1:0] set_idx;
	logic [OFFS_W-1:0]   word_offs;

	assign set_idx   = i_addr[OFFS_W +: SET_BITS];
	assign word_offs = i_addr[OFFS_W-1:0];

	// --------------------
	// read side
	// --------------------
	assign o_word        = data_mem[set_idx][i_way].words[word_offs];
	assign o_victim_line = data_mem[set_idx][i_way];  // whole line for write-back

	// --------------------
	// write side
	// --------------------
	// fill and word write never coincide, fill only happens in refill
	always_ff @(posedge clk) begin
		if (i_fill) begin
			data_mem[set_idx][i_way] <= i_fill_line;
		end else if (i_word_we) begin
			data_mem[set_idx][i_way].words[word_offs] <= i_wdata;
		end
	end

endmodule

`default_nettype wire

// ==== cache/cache_ctrl.sv ====
// miss FSM of the cache; the requester must hold address, data and strobes while stalled
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
	parameter int SET_BITS = cache_pkg::DEF_SET_BITS
) (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       i_proc_read,
	input  logic                                       i_proc_write,
	input  logic [cache_pkg::WORD_ADDR_W-1:0]          i_addr,
	input  logic                                       i_hit,
	input  logic                                       i_hit_way,
	input  logic                                       i_victim_way,
	input  logic                                       i_victim_valid,
	input  logic [cache_pkg::LINE_ADDR_W-SET_BITS-1:0] i_victim_tag,
	input  cache_pkg::line_u                           i_victim_line,
	input  logic                                       i_mem_ready,
	output logic                                       o_proc_stall,
	output cache_pkg::mem_req_t                        o_mem_req,
	output logic                                       o_touch,
	output logic                                       o_fill,
	output logic                                       o_way,
	output logic                                       o_word_we
);
	import cache_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;
	logic         victim_way_q;  // stable way for the whole miss
	logic         req;
	logic         miss;

	logic [SET_BITS-1:0] set_idx;

	assign req     = i_proc_read | i_proc_write;
	assign set_idx = i_addr[OFFS_W +: SET_BITS];
	assign miss    = (state_q == READY) && req && !i_hit;

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			READY: begin
				if (miss)
					state_d = i_victim_valid ? WRITEBACK : REFILL;
			end
			WRITEBACK: begin
				if (i_mem_ready)
					state_d = REFILL;
			end
			REFILL: begin
				if (i_mem_ready)
					state_d = READY;  // request hits next cycle
			end
			default: state_d = READY;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= READY;
			victim_way_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (miss)
				victim_way_q <= i_victim_way;
		end
	end

	// --------------------
	// outputs
	// --------------------
	// stall stays low without a request, even mid-miss
	assign o_proc_stall = (state_q == READY) ? (req && !i_hit) : req;

	assign o_touch   = (state_q == READY) && req && i_hit;
	assign o_word_we = (state_q == READY) && i_proc_write && i_hit;
	assign o_fill    = (state_q == REFILL) && i_mem_ready;
	assign o_way     = (state_q == READY) ? i_hit_way : victim_way_q;

	always_comb begin
		o_mem_req = '0;
		case (state_q)
			WRITEBACK: begin
				o_mem_req.write = 1'b1;
				o_mem_req.addr  = {i_victim_tag, set_idx};  // old line's home
				o_mem_req.wdata = i_victim_line;
			end
			REFILL: begin
				o_mem_req.read = 1'b1;
				o_mem_req.addr = i_addr[WORD_ADDR_W-1:OFFS_W];
			end
			default: o_mem_req = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== cache/cache_top.sv ====
// 2-way set-associative cache top; one request in flight, memory answers with a one-cycle ready
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
	parameter int SET_BITS = cache_pkg::DEF_SET_BITS
) (
	input  logic                              clk,
	input  logic                              rst_n,
	// processor side
	input  logic                              i_proc_read,
	input  logic                              i_proc_write,
	input  logic [cache_pkg::WORD_ADDR_W-1:0] i_proc_addr,
	input  logic [cache_pkg::WORD_W-1:0]      i_proc_wdata,
	output logic [cache_pkg::WORD_W-1:0]      o_proc_rdata,
	output logic                              o_proc_stall,
	// memory side
	output cache_pkg::mem_req_t               o_mem_req,
	input  cache_pkg::line_u                  i_mem_rdata,
	input  logic                              i_mem_ready
);
	import cache_pkg::*;

	localparam int TAG_W = LINE_ADDR_W - SET_BITS;

	logic             hit;
	logic             hit_way;
	logic             victim_way;
	logic             victim_valid;
	logic [TAG_W-1:0] victim_tag;
	line_u            victim_line;
	logic             touch;
	logic             fill;
	logic             way;        // shared by tags and data
	logic             word_we;

	// --------------------
	// tags
	// --------------------
	cache_tag_store #(
		.SET_BITS (SET_BITS)
	) u_tags (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_addr         (i_proc_addr),
		.i_touch        (touch),
		.i_fill         (fill),
		.i_fill_way     (way),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_victim_way   (victim_way),
		.o_victim_valid (victim_valid),
		.o_victim_tag   (victim_tag)
	);

	// --------------------
	// data
	// --------------------
	cache_data_store #(
		.SET_BITS (SET_BITS)
	) u_data (
		.clk           (clk),
		.i_addr        (i_proc_addr),
		.i_way         (way),
		.i_word_we     (word_we),
		.i_wdata       (i_proc_wdata),
		.i_fill        (fill),
		.i_fill_line   (i_mem_rdata),  // taken in the ready cycle
		.o_word        (o_proc_rdata),
		.o_victim_line (victim_line)
	);

	// --------------------
	// control
	// --------------------
	cache_ctrl #(
		.SET_BITS (SET_BITS)
	) u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_proc_read    (i_proc_read),
		.i_proc_write   (i_proc_write),
		.i_addr         (i_proc_addr),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.i_victim_way   (victim_way),
		.i_victim_valid (victim_valid),
		.i_victim_tag   (victim_tag),
		.i_victim_line  (victim_line),
		.i_mem_ready    (i_mem_ready),
		.o_proc_stall   (o_proc_stall),
		.o_mem_req      (o_mem_req),
		.o_touch        (touch),
		.o_fill         (fill),
		.o_way          (way),
		.o_word_we      (word_we)
	);

endmodule

`default_nettype wire

// ==== tb/cache_chk.sv ====
// memory port protocol checks for cache_ctrl; assumes the enum state and struct request of cache_pkg
`timescale 1ns/1ps
`default_nettype none

module cache_chk (
	input logic                    clk,
	input logic                    rst_n,
	input cache_pkg::cache_state_e i_state,
	input cache_pkg::mem_req_t     i_mem_req,
	input logic                    i_mem_ready
);
	import cache_pkg::*;

	int unsigned fail_count = 0;  // assertion failures so far

	logic mem_active;

	assign mem_active = i_mem_req.read | i_mem_req.write;

	// --------------------
	// memory strobes
	// --------------------
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_mem_req.read && i_mem_req.write))
	else begin
		$error("memory read and write high together");
		fail_count++;
	end

	// request held until the ready pulse
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_active && !i_mem_ready |=> $stable(i_mem_req))
	else begin
		$error("memory request changed while waiting for ready");
		fail_count++;
	end

	a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(i_state == READY) |-> !mem_active)
	else begin
		$error("memory strobe high in READY");
		fail_count++;
	end

endmodule

bind cache_ctrl cache_chk u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_state     (state_q),
	.i_mem_req   (o_mem_req),
	.i_mem_ready (i_mem_ready)
);

`default_nettype wire

// ==== tb/tb_cache.sv ====
// random requests over a 64-word window against a tag/LRU model; memory answers in 1 to 6 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
	import cache_pkg::*;

	localparam int SET_BITS    = 2;
	localparam int NUM_SETS    = 1 << SET_BITS;
	localparam int TAG_W       = LINE_ADDR_W - SET_BITS;
	localparam int WIN_WORDS   = 64;
	localparam int WIN_LINES   = WIN_WORDS / LINE_WORDS;
	localparam int N_RANDOM    = 1930;
	localparam int N_TOTAL     = N_RANDOM + NUM_SETS + WIN_WORDS;
	localparam int STALL_MAX   = 64;                       // cycles before a miss counts as stuck
	localparam int WATCHDOG_NS = N_TOTAL * 20 * 8 + 200;
	localparam logic [31:0] SEED = 32'h97d07c5b;

	logic                   clk;
	logic                   rst_n;
	logic                   proc_read;
	logic                   proc_write;
	logic [WORD_ADDR_W-1:0] proc_addr;
	logic [WORD_W-1:0]      proc_wdata;
	logic [WORD_W-1:0]      proc_rdata;
	logic                   proc_stall;
	mem_req_t               mem_req;
	line_u                  mem_rdata;
	logic                   mem_ready;

	logic [LINE_W-1:0]      mem_lines [256];
	logic                   xfer_write_q [$];  // completed memory transfers
	logic [LINE_ADDR_W-1:0] xfer_addr_q [$];
	logic [LINE_W-1:0]      xfer_data_q [$];

	logic [WORD_W-1:0] shadow [WIN_WORDS];
	logic              m_valid [NUM_SETS][2];
	logic [TAG_W-1:0]  m_tag [NUM_SETS][2];
	logic              m_lru [NUM_SETS];       // names the LRU way
	logic [31:0]       stim_rng;
	logic              hung;
	int                data_errs;
	int                xfer_errs;
	int                stall_errs;

	cache_top #(
		.SET_BITS (SET_BITS)
	) u_cache_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc_read  (proc_read),
		.i_proc_write (proc_write),
		.i_proc_addr  (proc_addr),
		.i_proc_wdata (proc_wdata),
		.o_proc_rdata (proc_rdata),
		.o_proc_stall (proc_stall),
		.o_mem_req    (mem_req),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// line contents as the shadow sees them
	function automatic logic [LINE_W-1:0] shadow_line(input logic [LINE_ADDR_W-1:0] la);
		logic [LINE_W-1:0] line;
		for (int i = 0; i < LINE_WORDS; i++)
			line[i*WORD_W +: WORD_W] = shadow[int'(la) * LINE_WORDS + i];
		return line;
	endfunction

	// --------------------
	// memory model
	// --------------------
	initial begin
		logic [31:0] mem_rng;
		int          delay;
		logic        busy;
		mem_rng = ~SEED;
		delay   = 0;
		busy    = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < 256; i++)
			mem_lines[i] = '0;
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				busy = 1'b0;
			end else if (mem_ready) begin  // ready cycle ends the transfer
				xfer_write_q.push_back(mem_req.write);
				xfer_addr_q.push_back(mem_req.addr);
				xfer_data_q.push_back(mem_req.wdata.flat);
				if (mem_req.write)
					mem_lines[mem_req.addr[7:0]] = mem_req.wdata.flat;
				mem_ready <= 1'b0;
				busy = 1'b0;
			end else if (busy) begin
				delay = delay - 1;
				if (delay == 0) begin
					mem_ready <= 1'b1;
					mem_rdata <= mem_lines[mem_req.addr[7:0]];
				end
			end else if (mem_req.read || mem_req.write) begin
				mem_rng = xorshift32(mem_rng);
				delay   = 1 + int'(mem_rng % 6);
				busy    = 1'b1;
			end
		end
	end

	// --------------------
	// request and check
	// --------------------
	task automatic check_transfers(input int exp_n, input logic exp_wb,
			input logic [LINE_ADDR_W-1:0] wb_addr, input logic [LINE_W-1:0] wb_line,
			input logic [LINE_ADDR_W-1:0] rf_addr);
		if (xfer_write_q.size() != exp_n) begin
			$display("CHECK FAILED at %0t: %0d memory transfers, expected %0d",
				$time, xfer_write_q.size(), exp_n);
			xfer_errs++;
		end else begin
			if (exp_wb && (!xfer_write_q[0] || xfer_addr_q[0] !== wb_addr
					|| xfer_data_q[0] !== wb_line)) begin
				$display("CHECK FAILED at %0t: write-back of line %0d wrong", $time, wb_addr);
				xfer_errs++;
			end
			if (exp_n > 0 && (xfer_write_q[exp_n-1] || xfer_addr_q[exp_n-1] !== rf_addr)) begin
				$display("CHECK FAILED at %0t: refill of line %0d wrong", $time, rf_addr);
				xfer_errs++;
			end
		end
		xfer_write_q.delete();
		xfer_addr_q.delete();
		xfer_data_q.delete();
	endtask

	task automatic run_request(input logic is_write, input logic [5:0] waddr,
			input logic [WORD_W-1:0] wdata);
		logic [WORD_ADDR_W-1:0] addr;
		logic [TAG_W-1:0]       tag;
		logic [LINE_ADDR_W-1:0] wb_addr;
		logic                   exp_hit;
		logic                   exp_wb;
		int                     set;
		int                     way;
		int                     stalls;
		addr    = {24'd0, waddr};
		set     = int'(addr[OFFS_W +: SET_BITS]);
		tag     = addr[WORD_ADDR_W-1 -: TAG_W];
		exp_hit = 1'b1;
		exp_wb  = 1'b0;
		wb_addr = '0;
		if (m_valid[set][0] && m_tag[set][0] == tag) way = 0;
		else if (m_valid[set][1] && m_tag[set][1] == tag) way = 1;
		else begin
			exp_hit = 1'b0;
			if (!m_valid[set][0]) way = 0;
			else if (!m_valid[set][1]) way = 1;
			else begin
				way     = m_lru[set] ? 1 : 0;
				exp_wb  = 1'b1;
				wb_addr = {m_tag[set][way], SET_BITS'(set)};
			end
		end
		@(posedge clk);
		proc_read  <= !is_write;
		proc_write <= is_write;
		proc_addr  <= addr;
		proc_wdata <= wdata;
		stalls = 0;
		@(negedge clk);
		while (proc_stall && stalls < STALL_MAX) begin
			stalls++;
			@(negedge clk);
		end
		if (proc_stall) begin
			$display("request to word %0d still stalled after %0d cycles at %0t",
				waddr, STALL_MAX, $time);
			stall_errs++;
			hung = 1'b1;
		end else begin
			if (exp_hit && stalls != 0) begin
				$display("CHECK FAILED at %0t: hit on word %0d stalled %0d cycles",
					$time, waddr, stalls);
				stall_errs++;
			end
			if (!exp_hit && stalls == 0) begin
				$display("CHECK FAILED at %0t: miss on word %0d did not stall", $time, waddr);
				stall_errs++;
			end
			if (!is_write && proc_rdata !== shadow[waddr]) begin
				$display("CHECK FAILED at %0t: word %0d read %h, expected %h",
					$time, waddr, proc_rdata, shadow[waddr]);
				data_errs++;
			end
			check_transfers(exp_hit ? 0 : (exp_wb ? 2 : 1), exp_wb, wb_addr,
				shadow_line(wb_addr), addr[WORD_ADDR_W-1:OFFS_W]);
			if (is_write)
				shadow[waddr] = wdata;
			if (!exp_hit) begin
				m_valid[set][way] = 1'b1;
				m_tag[set][way]   = tag;
			end
			m_lru[set] = (way == 0);  // other way becomes LRU
		end
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		logic resident;
		int   total;
		rst_n      = 1'b0;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		stim_rng   = SEED;
		hung       = 1'b0;
		data_errs  = 0;
		xfer_errs  = 0;
		stall_errs = 0;
		for (int i = 0; i < WIN_WORDS; i++)
			shadow[i] = '0;
		for (int s = 0; s < NUM_SETS; s++) begin
			m_valid[s][0] = 1'b0;
			m_valid[s][1] = 1'b0;
			m_lru[s]      = 1'b0;
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		for (int s = 0; s < NUM_SETS && !hung; s++)  // cold misses, refill only
			run_request(1'b0, 6'(s * LINE_WORDS), '0);
		for (int i = 0; i < N_RANDOM && !hung; i++) begin
			stim_rng = xorshift32(stim_rng);
			run_request(stim_rng[0], stim_rng[6:1], xorshift32(stim_rng ^ 32'h1));
		end
		for (int w = 0; w < WIN_WORDS && !hung; w++)  // sweep evicts every set
			run_request(1'b0, 6'(w), '0);
		@(posedge clk);
		proc_read  <= 1'b0;
		proc_write <= 1'b0;

		// lines out of the cache must sit in memory as the shadow has them
		for (int l = 0; l < WIN_LINES && !hung; l++) begin
			resident = 1'b0;
			for (int w = 0; w < 2; w++)
				if (m_valid[l % NUM_SETS][w] && m_tag[l % NUM_SETS][w] == TAG_W'(l / NUM_SETS))
					resident = 1'b1;
			if (!resident && mem_lines[l] !== shadow_line(LINE_ADDR_W'(l))) begin
				$display("CHECK FAILED at %0t: memory line %0d differs from shadow", $time, l);
				data_errs++;
			end
		end

		total = data_errs + xfer_errs + stall_errs + int'(u_cache_top.u_ctrl.u_chk.fail_count);
		$display("errors: data %0d, transfer %0d, stall %0d, assertion %0d",
			data_errs, xfer_errs, stall_errs, u_cache_top.u_ctrl.u_chk.fail_count);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
common/cache_pkg.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_ctrl.sv
cache/cache_top.sv
tb/cache_chk.sv
tb/tb_cache.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cache
FILELIST := sim.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
